/* bus_pkg.sv */
// Bus-side types shared by the write buffer and its bus
// Address, data and byte mask words, plus the bus command struct

package bus_pkg;

	// Byte address on the memory bus
	typedef logic [31:0] address_t;

	// One bus data word
	typedef logic [31:0] data_t;

	// Byte write mask, bit n enables byte n of the data word
	typedef logic [3:0] wmask_t;

	// Everything the bus master presents with a request
	// rw is high for a write and low for a read
	typedef struct packed {
		logic rw;
		address_t address;
		data_t data;
		wmask_t wmask;
	} bus_cmd_t;

endpackage

/* wbuf_pkg.sv */
// Buffer-internal types of the posted-write buffer
// Queue entry struct, request route enum and the two FSM state enums

package wbuf_pkg;

	import bus_pkg::*;

	// A posted write waiting in the queue
	typedef struct packed {
		address_t address;
		data_t data;
		wmask_t wmask;
	} wq_entry_t;

	// Path taken by a CPU request in the current cycle
	typedef enum logic [1:0] {
		ROUTE_NONE,
		ROUTE_POSTED,
		ROUTE_DIRECT
	} route_t;

	// Control FSM
	typedef enum logic {
		ST_IDLE,
		ST_DIRECT
	} ctrl_state_t;

	// Bus arbiter FSM, one locked state per port
	typedef enum logic [1:0] {
		ARB_IDLE,
		ARB_PORT_A,
		ARB_PORT_B
	} arb_state_t;

endpackage

/* write_queue.sv */
// First-word-fall-through register queue of posted writes
// Circular array with read/write pointers and an occupancy count

`timescale 1ns/1ps

module write_queue import wbuf_pkg::*; #(
	parameter int DEPTH = 8
) (
	input logic i_clock,
	input logic i_reset,
	input logic i_push,
	input wq_entry_t i_entry,
	input logic i_pop,
	output wq_entry_t o_head,
	output logic o_empty,
	output logic o_full
);

	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	typedef logic [PTR_W-1:0] ptr_t;
	typedef logic [CNT_W-1:0] count_t;

	wq_entry_t slots [DEPTH];
	ptr_t rd_ptr;
	ptr_t wr_ptr;
	count_t count;
	logic do_push;
	logic do_pop;

	// Guard against overflow and underflow
	assign do_push = i_push && !o_full;
	assign do_pop = i_pop && !o_empty;

	assign o_empty = (count == '0);
	assign o_full = (count == count_t'(DEPTH));

	// Head is valid whenever the queue is not empty
	assign o_head = slots[rd_ptr];

	// Entry storage
	always_ff @(posedge i_clock) begin
		if (do_push) begin
			slots[wr_ptr] <= i_entry;
		end
	end

	// Pointers wrap explicitly so DEPTH need not be a power of two
	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= (wr_ptr == ptr_t'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == ptr_t'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// Push and pop together leave the count alone
			if (do_push && !do_pop) begin
				count <= count + 1'b1;
			end else if (do_pop && !do_push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

/* bus_arbiter.sv */
// Two-port bus arbiter with a per-transaction lock
// Port B (queue drain) wins over port A (direct path) from idle

`timescale 1ns/1ps

module bus_arbiter import bus_pkg::*, wbuf_pkg::*; (
	input logic i_clock,
	input logic i_reset,

	// Port A, direct reads and uncached writes
	input logic i_a_request,
	input bus_cmd_t i_a_cmd,
	output logic o_a_ready,
	output data_t o_a_rdata,

	// Port B, drain of posted writes
	input logic i_b_request,
	input bus_cmd_t i_b_cmd,
	output logic o_b_ready,

	// Memory bus
	output logic o_bus_request,
	output bus_cmd_t o_bus_cmd,
	input logic i_bus_ready,
	input data_t i_bus_rdata
);

	arb_state_t state;
	arb_state_t state_next;
	logic sel_a;
	logic sel_b;

	// Port selection, combinational from idle so a grant costs no cycle
	always_comb begin
		sel_a = 1'b0;
		sel_b = 1'b0;
		case (state)
			ARB_IDLE: begin
				if (i_b_request) begin
					sel_b = 1'b1;
				end else if (i_a_request) begin
					sel_a = 1'b1;
				end
			end
			ARB_PORT_A: sel_a = 1'b1;
			ARB_PORT_B: sel_b = 1'b1;
			default: begin
				sel_a = 1'b0;
				sel_b = 1'b0;
			end
		endcase
	end

	// Bus mux
	assign o_bus_request = (sel_a && i_a_request) || (sel_b && i_b_request);
	assign o_bus_cmd = sel_a ? i_a_cmd : i_b_cmd;

	// Ready goes back only to the owner
	assign o_a_ready = sel_a && i_bus_ready;
	assign o_b_ready = sel_b && i_bus_ready;
	assign o_a_rdata = i_bus_rdata;

	// Lock onto the chosen port until the bus acknowledges
	always_comb begin
		state_next = state;
		case (state)
			ARB_IDLE: begin
				if (sel_b && !i_bus_ready) begin
					state_next = ARB_PORT_B;
				end else if (sel_a && !i_bus_ready) begin
					state_next = ARB_PORT_A;
				end
			end
			ARB_PORT_A, ARB_PORT_B: begin
				if (i_bus_ready) begin
					state_next = ARB_IDLE;
				end
			end
			default: state_next = ARB_IDLE;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ARB_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

/* wbuf_control.sv */
// Control of the posted-write buffer
// Routes CPU requests to the queue or the direct bus port,
// and forms the drain command from the queue head

`timescale 1ns/1ps

module wbuf_control import bus_pkg::*, wbuf_pkg::*; #(
	parameter int DEPTH = 8
) (
	input logic i_clock,
	input logic i_reset,

	// CPU side
	input logic i_request,
	input logic i_rw,
	input logic i_cached,
	input address_t i_address,
	input data_t i_wdata,
	input wmask_t i_wmask,
	output logic o_ready,
	output data_t o_rdata,
	output logic o_empty,
	output logic o_full,

	// Queue side
	output logic o_push,
	output wq_entry_t o_entry,
	input wq_entry_t i_q_head,
	input logic i_q_empty,
	input logic i_q_full,
	output logic o_pop,

	// Arbiter side
	output logic o_a_request,
	output bus_cmd_t o_a_cmd,
	input logic i_a_ready,
	input data_t i_a_rdata,
	output logic o_b_request,
	output bus_cmd_t o_b_cmd,
	input logic i_b_ready
);

	ctrl_state_t state;
	ctrl_state_t state_next;
	route_t route;

	// Queue depth must allow at least two entries
	if (DEPTH < 2) begin : g_depth_check
		$error("wbuf_control: DEPTH must be 2 or more");
	end

	// Request classification
	always_comb begin
		route = ROUTE_NONE;
		if (state == ST_DIRECT) begin
			// Stay on the direct path until the bus answers
			route = ROUTE_DIRECT;
		end else if (i_request) begin
			if (i_rw && i_cached) begin
				if (!i_q_full) begin
					route = ROUTE_POSTED;
				end
			end else if (i_q_empty) begin
				// Reads and uncached writes only once all posted writes are out
				route = ROUTE_DIRECT;
			end
		end
	end

	// Posted path into the queue
	assign o_push = (route == ROUTE_POSTED);
	assign o_entry = '{address: i_address, data: i_wdata, wmask: i_wmask};

	// Direct path through arbiter port A
	assign o_a_request = (route == ROUTE_DIRECT);
	assign o_a_cmd = '{rw: i_rw, address: i_address, data: i_wdata, wmask: i_wmask};

	// Cached writes are readied at once, direct ones on the bus ready
	always_comb begin
		case (route)
			ROUTE_POSTED: o_ready = 1'b1;
			ROUTE_DIRECT: o_ready = i_a_ready;
			default: o_ready = 1'b0;
		endcase
	end

	assign o_rdata = i_a_rdata;
	assign o_empty = i_q_empty;
	assign o_full = i_q_full;

	// Drain, one queue entry per bus write
	assign o_b_request = !i_q_empty;
	assign o_b_cmd = '{
		rw: 1'b1,
		address: i_q_head.address,
		data: i_q_head.data,
		wmask: i_q_head.wmask
	};
	// Pop on acknowledge so an empty queue means nothing outstanding
	assign o_pop = i_b_ready;

	always_comb begin
		state_next = state;
		case (state)
			ST_IDLE: begin
				if (route == ROUTE_DIRECT && !i_a_ready) begin
					state_next = ST_DIRECT;
				end
			end
			ST_DIRECT: begin
				if (i_a_ready) begin
					state_next = ST_IDLE;
				end
			end
			default: state_next = ST_IDLE;
		endcase
	end

	always_ff @(posedge i_clock) begin
		if (i_reset) begin
			state <= ST_IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

/* write_buffer_top.sv */
// Posted-write buffer between a CPU load/store port and a memory bus
// Connects the control, the write queue and the bus arbiter

`timescale 1ns/1ps

module write_buffer_top import bus_pkg::*, wbuf_pkg::*; #(
	parameter int DEPTH = 8
) (
	input logic i_clock,
	input logic i_reset,

	// CPU side
	input logic i_request,
	input logic i_rw,
	input logic i_cached,
	input address_t i_address,
	input data_t i_wdata,
	input wmask_t i_wmask,
	output logic o_ready,
	output data_t o_rdata,
	output logic o_empty,
	output logic o_full,

	// Memory bus
	output logic o_bus_request,
	output bus_cmd_t o_bus_cmd,
	input logic i_bus_ready,
	input data_t i_bus_rdata
);

	logic q_push;
	wq_entry_t q_entry;
	wq_entry_t q_head;
	logic q_empty;
	logic q_full;
	logic q_pop;

	logic a_request;
	bus_cmd_t a_cmd;
	logic a_ready;
	data_t a_rdata;
	logic b_request;
	bus_cmd_t b_cmd;
	logic b_ready;

	wbuf_control #(
		.DEPTH(DEPTH)
	) u_control (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_request(i_request),
		.i_rw(i_rw),
		.i_cached(i_cached),
		.i_address(i_address),
		.i_wdata(i_wdata),
		.i_wmask(i_wmask),
		.o_ready(o_ready),
		.o_rdata(o_rdata),
		.o_empty(o_empty),
		.o_full(o_full),
		.o_push(q_push),
		.o_entry(q_entry),
		.i_q_head(q_head),
		.i_q_empty(q_empty),
		.i_q_full(q_full),
		.o_pop(q_pop),
		.o_a_request(a_request),
		.o_a_cmd(a_cmd),
		.i_a_ready(a_ready),
		.i_a_rdata(a_rdata),
		.o_b_request(b_request),
		.o_b_cmd(b_cmd),
		.i_b_ready(b_ready)
	);

	write_queue #(
		.DEPTH(DEPTH)
	) u_queue (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_push(q_push),
		.i_entry(q_entry),
		.i_pop(q_pop),
		.o_head(q_head),
		.o_empty(q_empty),
		.o_full(q_full)
	);

	bus_arbiter u_arbiter (
		.i_clock(i_clock),
		.i_reset(i_reset),
		.i_a_request(a_request),
		.i_a_cmd(a_cmd),
		.o_a_ready(a_ready),
		.o_a_rdata(a_rdata),
		.i_b_request(b_request),
		.i_b_cmd(b_cmd),
		.o_b_ready(b_ready),
		.o_bus_request(o_bus_request),
		.o_bus_cmd(o_bus_cmd),
		.i_bus_ready(i_bus_ready),
		.i_bus_rdata(i_bus_rdata)
	);

endmodule

/* write_buffer_assert.sv */
// Concurrent assertions on the write buffer top level, bound into it
// Bus handshake stability, exclusive status flags, reads only on an empty queue

`timescale 1ns/1ps

module write_buffer_assert import bus_pkg::*; (
	input logic i_clock,
	input logic i_reset,
	input logic i_bus_request,
	input bus_cmd_t i_bus_cmd,
	input logic i_bus_ready,
	input logic i_empty,
	input logic i_full
);

	// Number of assertion failures so far, read by the testbench
	int fail_count = 0;

	// A pending request keeps its command until the bus answers
	property p_bus_hold;
		@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_ready) |=> (i_bus_request && $stable(i_bus_cmd));
	endproperty

	a_bus_hold: assert property (p_bus_hold)
		else begin
			$error("Bus request or command changed before ready");
			fail_count++;
		end

	a_status: assert property (@(posedge i_clock) disable iff (i_reset) !(i_empty && i_full))
		else begin
			$error("Empty and full are high together");
			fail_count++;
		end

	// Reads wait until every posted write is acknowledged
	a_read_order: assert property (@(posedge i_clock) disable iff (i_reset)
		(i_bus_request && !i_bus_cmd.rw) |-> i_empty)
		else begin
			$error("Bus read while posted writes are pending");
			fail_count++;
		end

endmodule

bind write_buffer_top write_buffer_assert u_assert (
	.i_clock(i_clock),
	.i_reset(i_reset),
	.i_bus_request(o_bus_request),
	.i_bus_cmd(o_bus_cmd),
	.i_bus_ready(i_bus_ready),
	.i_empty(o_empty),
	.i_full(o_full)
);

/* tb_write_buffer.sv */
// Testbench of the posted-write buffer
// Random CPU accesses, a byte-masked bus memory with random delays,
// and a model of bus order and memory contents

`timescale 1ns/1ps

module tb_write_buffer import bus_pkg::*; ();

	localparam int DEPTH = 8;
	localparam int CLK_PERIOD = 40;
	// Outputs are sampled this long after the falling edge
	localparam int SAMPLE_DELAY = 10;
	localparam int TIMEOUT = 200;
	localparam int NUM_OPS = 400;

	logic i_clock;
	logic i_reset;
	logic i_request;
	logic i_rw;
	logic i_cached;
	address_t i_address;
	data_t i_wdata;
	wmask_t i_wmask;
	logic o_ready;
	data_t o_rdata;
	logic o_empty;
	logic o_full;
	logic o_bus_request;
	bus_cmd_t o_bus_cmd;
	logic i_bus_ready;
	data_t i_bus_rdata;

	data_t bus_mem [16];
	data_t shadow [16];
	bus_cmd_t expected_bus [$];
	int cpu_seed = 32'h782;
	int bus_seed = 32'h782;
	logic ack_enable;
	logic stall_bus;

	write_buffer_top #(.DEPTH(DEPTH)) UUT (.*);

	// Memory answers in the same cycle once its delay has run out
	assign i_bus_ready = ack_enable && o_bus_request;
	assign i_bus_rdata = bus_mem[o_bus_cmd.address[5:2]];

	initial begin
		i_clock = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) i_clock = ~i_clock;
		end
	end

	function automatic data_t fill_word(input logic [3:0] idx);
		return 32'h5A5A_0000 + idx * 32'h0001_0203;
	endfunction

	function automatic data_t apply_mask(input data_t old_word, input data_t new_word,
			input wmask_t mask);
		data_t result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (mask[b]) begin
				result[8*b +: 8] = new_word[8*b +: 8];
			end
		end
		return result;
	endfunction

	task automatic stop_run(input string what);
		$display("%s", what);
		$display("Checks failed");
		$fatal(1);
	endtask

	task automatic check_cmd(input string name, input bus_cmd_t expected, input bus_cmd_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("[FAIL] %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (actual !== expected) begin
			stop_run($sformatf("[FAIL] %s: expected %h actual %h", name, expected, actual));
		end
	endtask

	task automatic check_flag(input string name, input logic expected, input logic actual);
		if (actual !== expected) begin
			stop_run($sformatf("[FAIL] %s: expected %b actual %b", name, expected, actual));
		end
	endtask

	// Present one access at the falling edge and log its bus command
	task automatic drive_access(input logic rw, input logic cached, input logic [3:0] idx,
			input data_t wdata, input wmask_t wmask);
		bus_cmd_t cmd;
		cmd.rw = rw;
		cmd.address = {26'h40, idx, 2'b00};
		cmd.data = rw ? wdata : '0;
		cmd.wmask = rw ? wmask : '0;
		@(negedge i_clock);
		i_request = 1'b1;
		i_rw = rw;
		i_cached = cached;
		i_address = cmd.address;
		i_wdata = cmd.data;
		i_wmask = cmd.wmask;
		expected_bus.push_back(cmd);
	endtask

	// Wait for ready, then update or compare against the shadow memory
	task automatic finish_access(output int waited);
		waited = 0;
		#(SAMPLE_DELAY);
		while (!o_ready) begin
			if (waited == TIMEOUT) begin
				stop_run("CPU access was never readied");
			end
			waited++;
			@(negedge i_clock);
			#(SAMPLE_DELAY);
		end
		if (i_rw) begin
			shadow[i_address[5:2]] = apply_mask(shadow[i_address[5:2]], i_wdata, i_wmask);
		end else begin
			check_data("read data", shadow[i_address[5:2]], o_rdata);
		end
	endtask

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(negedge i_clock);
			i_request = 1'b0;
		end
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		idle_cycles(1);
		while (expected_bus.size() != 0) begin
			if (waited == TIMEOUT) begin
				stop_run("Posted writes did not drain to the bus");
			end
			waited++;
			idle_cycles(1);
		end
		#(SAMPLE_DELAY);
		check_flag("empty after drain", 1'b1, o_empty);
	endtask

	// Failures of the bound assertions
	always @(negedge i_clock) begin
		if (UUT.u_assert.fail_count != 0) begin
			stop_run("A bound assertion on the write buffer failed");
		end
	end

	// Bus memory responder and bus monitor
	initial begin
		bus_cmd_t held_cmd;
		bus_cmd_t exp_cmd;
		logic pending;
		int wait_left;
		ack_enable = 1'b0;
		pending = 1'b0;
		wait_left = 0;
		forever begin
			@(negedge i_clock);
			ack_enable = !stall_bus && (wait_left == 0);
			#(SAMPLE_DELAY);
			check_flag("empty and full exclusive", 1'b0, o_empty && o_full);
			if (pending) begin
				check_flag("bus request held", 1'b1, o_bus_request);
				check_cmd("bus command held", held_cmd, o_bus_cmd);
			end
			pending = o_bus_request && !i_bus_ready;
			held_cmd = o_bus_cmd;
			if (o_bus_request && i_bus_ready) begin
				if (!o_bus_cmd.rw) begin
					check_flag("queue empty at bus read", 1'b1, o_empty);
				end
				if (expected_bus.size() == 0) begin
					stop_run("Bus transaction with no CPU access behind it");
				end
				exp_cmd = expected_bus.pop_front();
				check_cmd("bus command order", exp_cmd, o_bus_cmd);
				if (o_bus_cmd.rw) begin
					bus_mem[o_bus_cmd.address[5:2]] = apply_mask(bus_mem[o_bus_cmd.address[5:2]],
						o_bus_cmd.data, o_bus_cmd.wmask);
				end
				wait_left = $unsigned($random(bus_seed)) % 7;
			end else if (o_bus_request && wait_left > 0) begin
				wait_left--;
			end
		end
	end

	initial begin
		int waited;
		int kind;
		logic rw;
		logic cached;
		i_reset = 1'b1;
		i_request = 1'b0;
		i_rw = 1'b0;
		i_cached = 1'b0;
		i_address = '0;
		i_wdata = '0;
		i_wmask = '0;
		stall_bus = 1'b0;
		for (int i = 0; i < 16; i++) begin
			bus_mem[i] = fill_word(4'(i));
			shadow[i] = fill_word(4'(i));
		end
		repeat (5) @(posedge i_clock);
		@(negedge i_clock);
		i_reset = 1'b0;
		#(SAMPLE_DELAY);
		check_flag("reset empty", 1'b1, o_empty);
		check_flag("reset full", 1'b0, o_full);
		check_flag("reset ready", 1'b0, o_ready);
		check_flag("reset bus request", 1'b0, o_bus_request);

		// Fill the queue while the bus is held off
		stall_bus = 1'b1;
		for (int i = 0; i < DEPTH; i++) begin
			drive_access(1'b1, 1'b1, 4'(i), $random(cpu_seed), 4'hF);
			finish_access(waited);
			check_flag("posted write readied at once", 1'b1, waited == 0);
		end
		drive_access(1'b1, 1'b1, 4'd8, $random(cpu_seed), 4'h5);
		for (int i = 0; i < 3; i++) begin
			#(SAMPLE_DELAY);
			check_flag("full with the bus stalled", 1'b1, o_full);
			check_flag("write held while full", 1'b0, o_ready);
			if (i == 2) begin
				stall_bus = 1'b0;
			end
			@(negedge i_clock);
		end
		finish_access(waited);
		waited = 0;
		do begin
			if (waited == TIMEOUT) begin
				stop_run("Full flag stayed high after the bus was released");
			end
			waited++;
			idle_cycles(1);
			#(SAMPLE_DELAY);
		end while (o_full);
		wait_drained();

		// Half cached writes, the rest reads and uncached writes
		for (int n = 0; n < NUM_OPS; n++) begin
			kind = $unsigned($random(cpu_seed)) % 10;
			rw = (kind < 7);
			cached = (kind < 5) || (!rw && kind[0]);
			drive_access(rw, cached, 4'($random(cpu_seed)), $random(cpu_seed),
				4'($random(cpu_seed)));
			finish_access(waited);
			idle_cycles($unsigned($random(cpu_seed)) % 3);
		end
		wait_drained();
		if (UUT.u_assert.fail_count == 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_run("A bound assertion on the write buffer failed");
		end
	end

endmodule

/* flist.f */
bus_pkg.sv
wbuf_pkg.sv
write_queue.sv
bus_arbiter.sv
wbuf_control.sv
write_buffer_top.sv
write_buffer_assert.sv
tb_write_buffer.sv
